// File: verilog/tile_video_pkg.sv
// tile video shared types
`default_nettype none

package tile_video_pkg;

    typedef logic [15:0] cpu_word_t;  // cpu data bus
    typedef logic [15:0] rom_addr_t;  // rom word address, bit 15 picks map or tile region
    typedef logic [31:0] rom_data_t;  // rom word, tile planes in low 24 bits
    typedef logic [8:0]  scr_pos_t;   // screen or scroll coordinate
    typedef logic [10:0] pixel_t;     // prio, palette[6:0], colour[2:0]

    // per layer scroll setup
    typedef struct packed {
        logic [2:0] page;
        scr_pos_t   hscr;
        scr_pos_t   vscr;
    } scroll_cfg_t;

    // one clk read strobe plus its address
    typedef struct packed {
        logic      rd;
        rom_addr_t addr;
    } fetch_req_t;

    // data only meaningful while ok is high
    typedef struct packed {
        logic      ok;
        rom_data_t data;
    } fetch_rsp_t;

    // requester slots: l0 map, l0 tile, l1 map, l1 tile
    parameter int NUM_REQ = 4;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP_WAIT,
        FETCH_TILE_WAIT
    } fetch_state_t;

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
// pixel enable and screen counters
`default_nettype none

module video_timing #(
    parameter int H_TOTAL = 400,
    parameter int V_TOTAL = 262,
    parameter int PXL_DIV = 4
) (
    input  wire                       clk,
    input  wire                       rst,
    output logic                      pxl_cen,
    output tile_video_pkg::scr_pos_t  hdump,
    output tile_video_pkg::scr_pos_t  vdump
);
    import tile_video_pkg::*;

    localparam int DIV_W = (PXL_DIV > 1) ? $clog2(PXL_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;  // clk phase inside one pixel
    logic             last_phase;
    logic             h_end;
    logic             v_end;

    assign last_phase = div_cnt == DIV_W'(PXL_DIV - 1);
    assign h_end      = hdump == scr_pos_t'(H_TOTAL - 1);
    assign v_end      = vdump == scr_pos_t'(V_TOTAL - 1);

    // divider, cen is a registered one clk pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            div_cnt <= last_phase ? '0 : div_cnt + 1'b1;
            pxl_cen <= last_phase;
        end
    end

    // raster position moves only on the pixel enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (h_end) begin
                hdump <= '0;
                vdump <= v_end ? '0 : vdump + 9'd1;  // next line or frame wrap
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/scroll_regs.sv
// cpu scroll registers
`default_nettype none

module scroll_regs (
    input  wire                          clk,
    input  wire                          rst,
    input  logic                         cs,
    input  logic [2:0]                   addr,
    input  tile_video_pkg::cpu_word_t    dout,
    input  logic [1:0]                   dsn,
    output tile_video_pkg::cpu_word_t    din,
    output tile_video_pkg::scroll_cfg_t  cfg0,
    output tile_video_pkg::scroll_cfg_t  cfg1
);
    import tile_video_pkg::*;

    // map: 0 page0, 1 vscr0, 2 hscr0, 3 page1, 4 vscr1, 5 hscr1
    localparam int NUM_REGS = 6;

    cpu_word_t regs [NUM_REGS];
    cpu_word_t cur_val;  // register under the address
    cpu_word_t wr_val;   // after byte lane merge
    logic      hit;      // addr 6 and 7 are unmapped

    assign hit     = addr < 3'(NUM_REGS);
    assign cur_val = hit ? regs[addr] : '0;

    // dsn low enables a lane
    always_comb begin
        wr_val = cur_val;
        if (!dsn[1]) wr_val[15:8] = dout[15:8];  // upper byte
        if (!dsn[0]) wr_val[7:0]  = dout[7:0];   // lower byte
    end

    // with dsn=11 this is a plain read, value unchanged
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            din <= '0;
        end else if (cs) begin
            if (hit) regs[addr] <= wr_val;
            din <= hit ? wr_val : '0;  // readback shows value after the access
        end
    end

    // only the bits the layers decode
    assign cfg0 = '{page: regs[0][2:0], hscr: regs[2][8:0], vscr: regs[1][8:0]};
    assign cfg1 = '{page: regs[3][2:0], hscr: regs[5][8:0], vscr: regs[4][8:0]};

endmodule

`default_nettype wire

// File: verilog/scroll_layer.sv
// scroll layer fetch and shifter
`default_nettype none

module scroll_layer #(
    parameter int H_ACTIVE = 320,
    parameter int V_ACTIVE = 224
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  tile_video_pkg::scr_pos_t     hdump,
    input  tile_video_pkg::scr_pos_t     vdump,
    input  tile_video_pkg::scroll_cfg_t  cfg,
    output tile_video_pkg::fetch_req_t   map_req,
    output tile_video_pkg::fetch_req_t   tile_req,
    input  tile_video_pkg::fetch_rsp_t   map_rsp,
    input  tile_video_pkg::fetch_rsp_t   tile_rsp,
    output tile_video_pkg::pixel_t       pxl
);
    import tile_video_pkg::*;

    scr_pos_t     hpos;        // scrolled column
    scr_pos_t     vpos;        // scrolled line
    logic [5:0]   next_col;    // map column of the following tile
    logic         fetch_en;    // visible area only
    logic         tile_start;  // first pixel of a tile column
    logic         tile_last;   // last pixel, shifter reload

    fetch_state_t state;
    logic         map_rd;
    logic         tile_rd;
    rom_addr_t    map_addr;
    rom_addr_t    tile_addr;

    logic [7:0]   attr_nxt;    // attribute for the next tile
    logic [23:0]  planes_nxt;  // pattern for the next tile
    logic [7:0]   sh_attr;
    logic [23:0]  sh_planes;   // three 8 pixel planes

    assign hpos       = hdump + cfg.hscr;
    assign vpos       = vdump + cfg.vscr;
    assign next_col   = hpos[8:3] + 6'd1;  // wraps at 64 columns
    assign fetch_en   = (hdump < scr_pos_t'(H_ACTIVE)) && (vdump < scr_pos_t'(V_ACTIVE));
    assign tile_start = pxl_cen && hpos[2:0] == 3'd0;
    assign tile_last  = hpos[2:0] == 3'd7;

    assign map_req  = '{rd: map_rd, addr: map_addr};
    assign tile_req = '{rd: tile_rd, addr: tile_addr};

    // map read then tile read, one outstanding per port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= FETCH_IDLE;
            map_rd  <= 1'b0;
            tile_rd <= 1'b0;
        end else begin
            map_rd  <= 1'b0;  // strobes last one clk
            tile_rd <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    if (tile_start && fetch_en) begin
                        map_rd <= 1'b1;
                        state  <= FETCH_MAP_WAIT;
                    end
                end
                FETCH_MAP_WAIT: begin
                    if (map_rsp.ok) begin
                        tile_rd <= 1'b1;
                        state   <= FETCH_TILE_WAIT;
                    end
                end
                FETCH_TILE_WAIT: begin
                    if (tile_rsp.ok) state <= FETCH_IDLE;
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // read addresses, held until the next request
    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && tile_start && fetch_en) begin
            // map region: page, row, column
            map_addr <= {2'b00, cfg.page, vpos[7:3], next_col};
        end
        if (state == FETCH_MAP_WAIT && map_rsp.ok) begin
            // tile region: code from the map word, line inside the tile
            tile_addr <= {1'b1, map_rsp.data[11:0], vpos[2:0]};
        end
    end

    // fetched data waits here for the reload point
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            attr_nxt   <= '0;
            planes_nxt <= '0;
        end else begin
            if (state == FETCH_MAP_WAIT && map_rsp.ok)
                attr_nxt <= map_rsp.data[12:5];  // prio + palette
            // a late tile leaves the old pattern in place
            if (state == FETCH_TILE_WAIT && tile_rsp.ok)
                planes_nxt <= tile_rsp.data[23:0];
        end
    end

    // shifter runs one pixel ahead of pxl
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sh_attr   <= '0;
            sh_planes <= '0;
            pxl       <= '0;
        end else if (pxl_cen) begin
            pxl <= {sh_attr, sh_planes[23], sh_planes[15], sh_planes[7]};
            if (tile_last) begin
                sh_attr   <= attr_nxt;
                sh_planes <= planes_nxt;
            end else begin
                sh_planes <= {sh_planes[22:16], 1'b0,
                              sh_planes[14:8],  1'b0,
                              sh_planes[6:0],   1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rom_arbiter.sv
// round robin rom arbiter
`default_nettype none

module rom_arbiter (
    input  wire                         clk,
    input  wire                         rst,
    input  tile_video_pkg::fetch_req_t  req [tile_video_pkg::NUM_REQ],
    output tile_video_pkg::fetch_rsp_t  rsp [tile_video_pkg::NUM_REQ],
    output logic                        mem_rd,
    output tile_video_pkg::rom_addr_t   mem_addr,
    input  wire                         mem_ok,
    input  tile_video_pkg::rom_data_t   mem_data
);
    import tile_video_pkg::*;

    localparam int IDX_W = $clog2(NUM_REQ);

    logic [NUM_REQ-1:0] req_rd;   // strobes this clk
    logic [NUM_REQ-1:0] pending;  // strobes not yet granted
    logic [NUM_REQ-1:0] want;
    rom_addr_t          addr_q [NUM_REQ];
    logic [IDX_W-1:0]   last;     // last granted slot
    logic [IDX_W-1:0]   owner;    // slot of the read in flight
    logic [IDX_W-1:0]   idx;
    logic [IDX_W-1:0]   nxt;
    logic               nxt_vld;
    logic               busy;
    logic               free;     // no read in flight after this clk
    logic               grant;

    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            req_rd[i] = req[i].rd;
        end
    end

    // a fresh strobe can win in its own clk
    assign want  = pending | req_rd;
    assign free  = !busy || mem_ok;
    assign grant = free && nxt_vld;

    // search starts just after the last winner
    always_comb begin
        nxt_vld = 1'b0;
        nxt     = last;
        idx     = last;
        for (int i = 1; i <= NUM_REQ; i++) begin
            idx = IDX_W'((int'(last) + i) % NUM_REQ);
            if (!nxt_vld && want[idx]) begin
                nxt_vld = 1'b1;
                nxt     = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= '0;
            busy    <= 1'b0;
            mem_rd  <= 1'b0;
            last    <= '0;
            owner   <= '0;
        end else begin
            mem_rd  <= 1'b0;
            pending <= want;
            if (mem_ok) busy <= 1'b0;
            if (grant) begin
                mem_rd       <= 1'b1;
                busy         <= 1'b1;  // wins over the ok clear
                pending[nxt] <= 1'b0;
                owner        <= nxt;
                last         <= nxt;
            end
        end
    end

    // addresses kept per slot, strobe cycle bypasses
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REQ; i++) begin
            if (req_rd[i]) addr_q[i] <= req[i].addr;
        end
        if (grant) mem_addr <= req_rd[nxt] ? req[nxt].addr : addr_q[nxt];
    end

    // ok goes back to the owner in the same clk
    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) begin
            rsp[i].ok   = busy && mem_ok && owner == IDX_W'(i);
            rsp[i].data = mem_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/layer_mixer.sv
// two layer priority mixer
`default_nettype none

module layer_mixer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     pxl_cen,
    input  tile_video_pkg::pixel_t  bg,
    input  tile_video_pkg::pixel_t  fg,
    output tile_video_pkg::pixel_t  pxl
);
    import tile_video_pkg::*;

    logic   fg_opaque;  // fg colour nonzero
    logic   bg_front;   // bg prio bit and a visible colour
    pixel_t mix;

    assign fg_opaque = fg[2:0] != 3'd0;
    assign bg_front  = bg[10] && bg[2:0] != 3'd0;

    // bg also shows through where fg is transparent
    assign mix = (fg_opaque && !bg_front) ? fg : bg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= mix;  // second pixel of latency
        end
    end

endmodule

`default_nettype wire

// File: verilog/tile_video.sv
// two layer tile video top
`default_nettype none

module tile_video #(
    parameter int H_TOTAL  = 400,
    parameter int V_TOTAL  = 262,
    parameter int H_ACTIVE = 320,
    parameter int V_ACTIVE = 224,
    parameter int PXL_DIV  = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  logic                       cs,
    input  logic [2:0]                 addr,
    input  tile_video_pkg::cpu_word_t  dout,
    input  logic [1:0]                 dsn,
    output tile_video_pkg::cpu_word_t  din,
    output logic                       mem_rd,
    output tile_video_pkg::rom_addr_t  mem_addr,
    input  wire                        mem_ok,
    input  tile_video_pkg::rom_data_t  mem_data,
    output tile_video_pkg::scr_pos_t   hdump,
    output tile_video_pkg::scr_pos_t   vdump,
    output tile_video_pkg::pixel_t     pxl
);
    import tile_video_pkg::*;

    logic        pxl_cen;
    scroll_cfg_t cfg0;
    scroll_cfg_t cfg1;
    fetch_req_t  req [NUM_REQ];  // l0 map, l0 tile, l1 map, l1 tile
    fetch_rsp_t  rsp [NUM_REQ];
    pixel_t      pxl0;           // background
    pixel_t      pxl1;           // foreground

    video_timing #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL),
        .PXL_DIV (PXL_DIV)
    ) u_timing (
        .clk, .rst, .pxl_cen, .hdump, .vdump
    );

    scroll_regs u_regs (
        .clk, .rst, .cs, .addr, .dout, .dsn, .din, .cfg0, .cfg1
    );

    scroll_layer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_layer0 (
        .clk, .rst, .pxl_cen, .hdump, .vdump,
        .cfg      (cfg0),
        .map_req  (req[0]),
        .tile_req (req[1]),
        .map_rsp  (rsp[0]),
        .tile_rsp (rsp[1]),
        .pxl      (pxl0)
    );

    scroll_layer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_layer1 (
        .clk, .rst, .pxl_cen, .hdump, .vdump,
        .cfg      (cfg1),
        .map_req  (req[2]),
        .tile_req (req[3]),
        .map_rsp  (rsp[2]),
        .tile_rsp (rsp[3]),
        .pxl      (pxl1)
    );

    rom_arbiter u_arb (
        .clk, .rst, .req, .rsp, .mem_rd, .mem_addr, .mem_ok, .mem_data
    );

    layer_mixer u_mixer (
        .clk, .rst, .pxl_cen,
        .bg  (pxl0),
        .fg  (pxl1),
        .pxl
    );

endmodule

`default_nettype wire

// File: tests/gfx_rom_model.sv
// graphics rom model
`default_nettype none

module gfx_rom_model #(
    parameter int SEED = 77026
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        rd,
    input  tile_video_pkg::rom_addr_t  addr,
    output logic                       ok,
    output tile_video_pkg::rom_data_t  data
);
    import tile_video_pkg::*;

    logic [31:0] lcg_state;
    logic [31:0] lcg_nxt;
    logic [2:0]  lat;       // 1 to 5 clks
    logic [2:0]  wait_cnt;  // clks left until ok
    rom_addr_t   addr_q;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // contents are a hash of the whole address
    function automatic rom_data_t rom_word_at(input rom_addr_t a);
        logic [31:0] h;
        if (!a[15]) begin
            if (a[13:11] == 3'd7) return '0;  // page 7 is blank, code 0
            h = {16'h0, a} * 32'h2c1b3c6d;
            h = h ^ (h >> 15);
        end else begin
            if (a[14:3] == 12'd0) return '0;  // tile code 0 is empty
            h = {16'h0, a} * 32'h9e3779b1;
            h = h ^ (h >> 13);
        end
        return h;
    endfunction

    assign lcg_nxt = lcg_step(lcg_state);
    assign lat     = 3'd1 + 3'(lcg_nxt[23:16] % 8'd5);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ok        <= 1'b0;
            data      <= '0;
            wait_cnt  <= '0;
            addr_q    <= '0;
            lcg_state <= 32'(SEED);
        end else begin
            ok <= 1'b0;  // single clk pulse
            if (rd) begin
                lcg_state <= lcg_nxt;  // new latency per read
                addr_q    <= addr;
                if (lat == 3'd1) begin
                    ok       <= 1'b1;
                    data     <= rom_word_at(addr);
                    wait_cnt <= '0;
                end else begin
                    wait_cnt <= lat - 3'd1;
                end
            end else if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;
                if (wait_cnt == 3'd1) begin
                    ok   <= 1'b1;
                    data <= rom_word_at(addr_q);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tile_video_tb.sv
// tile video testbench
`default_nettype none

module tile_video_tb;
    import tile_video_pkg::*;

    localparam int H_TOTAL   = 400;
    localparam int V_TOTAL   = 262;
    localparam int H_ACTIVE  = 320;
    localparam int V_ACTIVE  = 224;
    localparam int PXL_DIV   = 4;
    localparam int WAIT_MAX  = 2 * H_TOTAL * V_TOTAL * PXL_DIV;  // two frames in clks
    localparam int FIRST_COL = 16;  // earlier columns hold the previous line's tiles

    logic        clk;
    logic        rst;
    logic        cs;
    logic [2:0]  addr;
    cpu_word_t   dout;
    logic [1:0]  dsn;
    cpu_word_t   din;
    logic        mem_rd;
    rom_addr_t   mem_addr;
    logic        mem_ok;
    rom_data_t   mem_data;
    scr_pos_t    hdump;
    scr_pos_t    vdump;
    pixel_t      pxl;

    cpu_word_t   shadow [6];  // expected register contents
    string       test_name;
    int          pix_errors;
    int          reg_errors;
    int          ctl_errors;
    logic        pix_check_on;
    scr_pos_t    col;         // column now on pxl
    pixel_t      exp_pxl;
    logic        check_en;
    logic        raster_moved;
    logic        started;     // first pixel enable has passed
    int          rd_count;    // rom reads in flight
    logic [NUM_REQ-1:0] strobe_v;
    logic [NUM_REQ-1:0] ok_v;
    logic [NUM_REQ-1:0] slot_busy;
    scr_pos_t    h_prev;      // raster one clk ago
    scr_pos_t    v_prev;
    scr_pos_t    h_exp;
    scr_pos_t    v_exp;
    logic        h_moved;
    int          h_age;       // clks since hdump last stepped

    tile_video #(
        .H_TOTAL  (H_TOTAL),
        .V_TOTAL  (V_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .PXL_DIV  (PXL_DIV)
    ) dut0 (
        .clk, .rst, .cs, .addr, .dout, .dsn, .din,
        .mem_rd, .mem_addr, .mem_ok, .mem_data,
        .hdump, .vdump, .pxl
    );

    gfx_rom_model #(.SEED(77026)) rom0 (
        .clk, .rst,
        .rd   (mem_rd),
        .addr (mem_addr),
        .ok   (mem_ok),
        .data (mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // same formulas as the rom model
    function automatic rom_data_t map_word_at(input rom_addr_t a);
        logic [31:0] h;
        if (a[13:11] == 3'd7) return '0;
        h = {16'h0, a} * 32'h2c1b3c6d;
        return h ^ (h >> 15);
    endfunction

    function automatic rom_data_t tile_word_at(input rom_addr_t a);
        logic [31:0] h;
        if (a[14:3] == 12'd0) return '0;
        h = {16'h0, a} * 32'h9e3779b1;
        return h ^ (h >> 13);
    endfunction

    // one layer pixel at a screen position
    function automatic pixel_t layer_pixel(input scr_pos_t h, input scr_pos_t v,
                                           input logic [2:0] page,
                                           input scr_pos_t hscr, input scr_pos_t vscr);
        scr_pos_t  hp;
        scr_pos_t  vp;
        rom_data_t mw;
        rom_data_t tw;
        int        b;
        hp = h + hscr;  // both wrap at 512
        vp = v + vscr;
        mw = map_word_at({2'b00, page, vp[7:3], hp[8:3]});
        tw = tile_word_at({1'b1, mw[11:0], vp[2:0]});
        b  = 7 - int'(hp[2:0]);  // leftmost pixel in the plane msb
        return {mw[12:5], tw[16 + b], tw[8 + b], tw[b]};
    endfunction

    function automatic pixel_t mix_pixels(input pixel_t bg, input pixel_t fg);
        if (fg[2:0] != 3'd0 && !(bg[10] && bg[2:0] != 3'd0)) return fg;
        return bg;
    endfunction

    // pxl lags hdump by two columns
    always_comb begin
        col      = hdump - 9'd2;
        exp_pxl  = mix_pixels(
            layer_pixel(col, vdump, shadow[0][2:0], shadow[2][8:0], shadow[1][8:0]),
            layer_pixel(col, vdump, shadow[3][2:0], shadow[5][8:0], shadow[4][8:0]));
        check_en = pix_check_on && hdump >= 9'(FIRST_COL + 2) &&
                   hdump < 9'(H_ACTIVE + 2) && vdump < 9'(V_ACTIVE);
    end

    // next raster position, line end wraps to column 0 of the next line
    assign h_moved = hdump != h_prev;
    assign h_exp   = !h_moved ? h_prev :
                     (h_prev == 9'(H_TOTAL - 1)) ? '0 : h_prev + 9'd1;
    assign v_exp   = !h_moved ? v_prev :
                     (h_prev != 9'(H_TOTAL - 1)) ? v_prev :
                     (v_prev == 9'(V_TOTAL - 1)) ? '0 : v_prev + 9'd1;

    assign started  = raster_moved || hdump != '0 || vdump != '0;
    assign strobe_v = {dut0.req[3].rd, dut0.req[2].rd, dut0.req[1].rd, dut0.req[0].rd};
    assign ok_v     = {dut0.rsp[3].ok, dut0.rsp[2].ok, dut0.rsp[1].ok, dut0.rsp[0].ok};

    // rom and per slot bookkeeping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster_moved <= 1'b0;
            rd_count     <= 0;
            slot_busy    <= '0;
            h_prev       <= '0;
            v_prev       <= '0;
            h_age        <= 0;
        end else begin
            if (hdump != '0 || vdump != '0) raster_moved <= 1'b1;
            rd_count  <= rd_count + (mem_rd ? 1 : 0) - (mem_ok ? 1 : 0);
            slot_busy <= (slot_busy | strobe_v) & ~ok_v;
            h_prev    <= hdump;
            v_prev    <= vdump;
            h_age     <= h_moved ? 1 : h_age + 1;
        end
    end

    reset_quiet: assert property (@(negedge clk) !rst || (!mem_rd && pxl == '0 && din == '0))
        else begin
            ctl_errors++;
            $display("outputs are not idle while reset is held");
        end

    early_read: assert property (@(negedge clk) disable iff (rst) !mem_rd || started)
        else begin
            ctl_errors++;
            $display("a ROM read was issued before the first pixel enable");
        end

    raster_step: assert property (@(negedge clk) disable iff (rst)
            hdump == h_exp && vdump == v_exp)
        else begin
            ctl_errors++;
            $display("[FAIL] %s raster: expected %0d,%0d, actual %0d,%0d",
                     test_name, h_exp, v_exp, hdump, vdump);
        end

    pixel_rate: assert property (@(negedge clk) disable iff (rst)
            !raster_moved || (h_moved ? h_age == PXL_DIV : h_age < PXL_DIV))
        else begin
            ctl_errors++;
            $display("the raster did not advance once per pixel period");
        end

    single_read: assert property (@(negedge clk) disable iff (rst)
            (!mem_rd || rd_count == 0) && (!mem_ok || rd_count == 1))
        else begin
            ctl_errors++;
            $display("ROM read overlaps another read, or ok came without a read");
        end

    slot_pairing: assert property (@(negedge clk) disable iff (rst)
            (strobe_v & slot_busy) == '0 && (ok_v & ~slot_busy) == '0)
        else begin
            ctl_errors++;
            $display("a fetch port strobed while waiting, or got an ok it did not ask for");
        end

    pixel_match: assert property (@(negedge clk) disable iff (rst)
            !check_en || pxl == exp_pxl)
        else begin
            pix_errors++;
            if (pix_errors <= 10)
                $display("[FAIL] %s col %0d line %0d: expected %h, actual %h",
                         test_name, col, vdump, exp_pxl, pxl);
        end

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic wait_for_line(input int line);
        int n;
        n = 0;
        while (vdump != scr_pos_t'(line)) begin
            @(posedge clk);
            n++;
            if (n > WAIT_MAX) abort_on_timeout($sformatf("line %0d", line));
        end
    endtask

    // one cpu cycle followed by readback and hold checks
    task automatic cpu_access(input logic [2:0] a, input cpu_word_t val, input logic [1:0] lanes);
        cpu_word_t want;
        @(posedge clk);
        cs   <= 1'b1;
        addr <= a;
        dout <= val;
        dsn  <= lanes;
        @(posedge clk);
        cs   <= 1'b0;
        dsn  <= 2'b11;
        want = shadow[a];
        if (!lanes[1]) want[15:8] = val[15:8];
        if (!lanes[0]) want[7:0] = val[7:0];
        shadow[a] = want;
        @(negedge clk);
        assert (din == want) else begin
            reg_errors++;
            $display("[FAIL] %s reg %0d readback: expected %h, actual %h",
                     test_name, a, want, din);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (din == want) else begin
            reg_errors++;
            $display("[FAIL] %s reg %0d hold: expected %h, actual %h", test_name, a, want, din);
        end
    endtask

    // writes in vblank with junk in the unused upper bits
    task automatic set_layers(input logic [2:0] page0, input scr_pos_t hs0, input scr_pos_t vs0,
                              input logic [2:0] page1, input scr_pos_t hs1, input scr_pos_t vs1);
        wait_for_line(V_ACTIVE);
        cpu_access(3'd0, {13'h1a50, page0}, 2'b00);
        cpu_access(3'd1, {7'h2b, vs0}, 2'b00);
        cpu_access(3'd2, {7'h54, hs0}, 2'b00);
        cpu_access(3'd3, {13'h0f08, page1}, 2'b00);
        cpu_access(3'd4, {7'h61, vs1}, 2'b00);
        cpu_access(3'd5, {7'h1e, hs1}, 2'b00);
    endtask

    task automatic check_frame(input string name);
        test_name = name;
        @(posedge clk);
        pix_check_on <= 1'b1;
        wait_for_line(0);
        wait_for_line(V_ACTIVE);  // whole visible area seen
        @(posedge clk);
        pix_check_on <= 1'b0;
    endtask

    initial begin
        rst          = 1'b1;
        cs           = 1'b0;
        addr         = '0;
        dout         = '0;
        dsn          = 2'b11;
        pix_check_on = 1'b0;
        pix_errors   = 0;
        reg_errors   = 0;
        ctl_errors   = 0;
        test_name    = "reset";
        for (int i = 0; i < 6; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!mem_rd && pxl == '0 && din == '0) else begin
            ctl_errors++;
            $display("outputs are not zero after reset");
        end

        // byte lanes on every register then plain reads
        test_name = "reg_lanes";
        for (int i = 0; i < 6; i++) begin
            cpu_access(3'(i), 16'ha5c3 ^ 16'(i * 16'h1111), 2'b00);
        end
        cpu_access(3'd2, 16'h1234, 2'b01);  // upper byte only
        cpu_access(3'd4, 16'h5678, 2'b10);  // lower byte only
        cpu_access(3'd1, 16'hffff, 2'b11);  // no lane
        for (int i = 0; i < 6; i++) begin
            cpu_access(3'(i), 16'h0000, 2'b11);
        end

        set_layers(3'd2, 9'd0, 9'd0, 3'd7, 9'd21, 9'd3);
        check_frame("layer0_only");
        set_layers(3'd2, 9'd13, 9'd5, 3'd7, 9'd0, 9'd0);
        check_frame("scroll_offset");
        set_layers(3'd4, 9'd499, 9'd509, 3'd7, 9'd0, 9'd0);
        check_frame("scroll_wrap");
        set_layers(3'd3, 9'd6, 9'd250, 3'd5, 9'd37, 9'd300);
        check_frame("two_layers");
        set_layers(3'd1, 9'd301, 9'd77, 3'd6, 9'd450, 9'd9);
        check_frame("two_layers_wrap");

        // nothing may be left in flight in vblank
        @(negedge clk);
        assert (slot_busy == '0 && rd_count == 0) else begin
            ctl_errors++;
            $display("a fetch strobe never received its ok");
        end

        $display("errors: pixel %0d, register %0d, control %0d",
                 pix_errors, reg_errors, ctl_errors);
        if (pix_errors == 0 && reg_errors == 0 && ctl_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
verilog/tile_video_pkg.sv
verilog/video_timing.sv
verilog/scroll_regs.sv
verilog/scroll_layer.sv
verilog/rom_arbiter.sv
verilog/layer_mixer.sv
verilog/tile_video.sv
tests/gfx_rom_model.sv
tests/tile_video_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tile_video_tb \
    -f sim.f \
    -Mdir obj_dir \
    -o tile_video_sim

./obj_dir/tile_video_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
